// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_synth
RTL_TOP   ?= synth_interface
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation passed

RTL_SRCS := $(filter-out tb_%.sv,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
synth_pkg.sv
synth_ctrl.sv
voice.sv
voice_mixer.sv
sd_dac.sv
synth_interface.sv
tb_synth.sv

// File: sd_dac.sv
// ----------------------------------------------------------------------
// First order sigma-delta DAC, one bit output at clk rate
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sd_dac (
	input  logic               clk,
	input  logic               rst,
	input  synth_pkg::sample_t pcm,
	output logic               pwmout
);

	import synth_pkg::*;

	sample_t           acc;
	logic [BITDEPTH:0] acc_sum; // Carry in the top bit

	assign acc_sum = {1'b0, acc} + {1'b0, pcm};

	// Carry density tracks pcm / 2**BITDEPTH
	always_ff @(posedge clk) begin
		if (rst) begin
			acc    <= '0;
			pwmout <= 1'b0;
		end else begin
			acc    <= acc_sum[BITDEPTH-1:0];
			pwmout <= acc_sum[BITDEPTH];
		end
	end

endmodule

// File: synth_ctrl.sv
// ----------------------------------------------------------------------
// Synth control: CPU register file with strobe/ready handshake,
// readback of voice settings and the sample tick divider
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module synth_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [7:0]             addr,    // [7:4] voice, [3:0] register
	input  logic [31:0]            data_in,
	input  logic                   wen,
	input  logic                   ren,
	output logic [31:0]            data_out,
	output logic                   ready,
	output synth_pkg::voice_cfg_t  cfg [synth_pkg::NUM_VOICES],
	output logic                   sample_tick
);

	import synth_pkg::*;

	logic                  strobe_q;    // Strobe seen last cycle
	logic                  wr_fire;     // Write commits this cycle
	logic                  voice_ok;    // Address inside the voice slots
	logic [VSEL_BITS-1:0]  voice_idx;
	logic [3:0]            reg_sel;
	logic [31:0]           rdata;       // Readback mux
	logic [SAMPLE_DIV-1:0] sample_cnt;

	assign voice_idx = addr[VSEL_BITS+3:4];
	assign reg_sel   = addr[3:0];
	assign voice_ok  = (addr[7:4] < 4'(NUM_VOICES));

	// Ready follows the registered strobe but drops with the live one
	assign ready   = strobe_q & (wen | ren);
	assign wr_fire = strobe_q & wen;

	always_ff @(posedge clk) begin
		if (rst) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= wen | ren;
		end
	end

	// Register file
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_VOICES; i++) begin
				cfg[i] <= CFG_RESET; // All voices silent
			end
		end else if (wr_fire && voice_ok) begin
			case (reg_sel)
				REG_PLAY: begin
					if (data_in[31]) begin // Gate on with a new pitch
						cfg[voice_idx].gate <= 1'b1;
						cfg[voice_idx].inc  <= data_in[INC_BITS-1:0];
					end else begin
						cfg[voice_idx].gate <= 1'b0; // Pitch kept
					end
				end
				REG_AR: begin
					cfg[voice_idx].attack <= data_in[AR_BITS-1:0];
					cfg[voice_idx].rel    <= data_in[2*AR_BITS-1:AR_BITS];
				end
				default: ; // Unmapped, dropped
			endcase
		end
	end

	// Readback, zero outside the map
	always_comb begin
		rdata = '0;
		if (voice_ok) begin
			case (reg_sel)
				REG_PLAY: begin
					rdata[31]           = cfg[voice_idx].gate;
					rdata[INC_BITS-1:0] = cfg[voice_idx].inc;
				end
				REG_AR: begin
					rdata[AR_BITS-1:0]         = cfg[voice_idx].attack;
					rdata[2*AR_BITS-1:AR_BITS] = cfg[voice_idx].rel;
				end
				default: rdata = '0;
			endcase
		end
	end

	// Data lines up with ready, one cycle after the read strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			data_out <= '0;
		end else if (ren) begin
			data_out <= rdata;
		end else begin
			data_out <= '0;
		end
	end

	// Free running divider, one tick per 2**SAMPLE_DIV cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			sample_cnt  <= '0;
			sample_tick <= 1'b0;
		end else begin
			sample_cnt  <= sample_cnt + 1'b1;
			sample_tick <= &sample_cnt; // Pulse on wrap
		end
	end

endmodule

// File: synth_golden.txt
# op addr data : W writes data, R reads and compares data (hex)
# S sample : next pcm_sample (hex), P : pwmout ones over 256 cycles
R 00 00001770
R 04 0000F0F0
R 10 00001770
R 14 0000F0F0
R 20 00001770
R 24 0000F0F0
R 30 00001770
R 34 0000F0F0
R 40 00001770
R 44 0000F0F0
R 50 00001770
R 54 0000F0F0
R 60 00001770
R 64 0000F0F0
R 70 00001770
R 74 0000F0F0
R 08 00000000
R 7C 00000000
R 80 00000000
S 0000
S 0000
W 14 00003456
R 14 00003456
W 10 80001234
R 10 80001234
W 10 00005555
R 10 00001234
W 18 FFFFFFFF
W 90 80000001
R 10 00001234
R 14 00003456
S 0000
W 04 0000FFFF
W 00 80002000
S 000F
S 003E
S 008D
S 00FC
W 00 00000000
S 00EB
S 00BA
S 0069
S 0000
W 24 0000FFFF
W 44 0000FFFF
W 20 80004000
W 40 80003000
S 002D
S 01B1
S 02C0
P
W 20 00000000
W 40 00000000
S 002E
S 0135
S 00C2
S 0000
P

// File: synth_interface.sv
// ----------------------------------------------------------------------
// Synth top: CPU registers, eight voices, mixer and sigma-delta output
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module synth_interface (
	input  logic               clk,
	input  logic               rst,
	input  logic [7:0]         addr,
	input  logic [31:0]        data_in,
	input  logic               wen,
	input  logic               ren,
	output logic [31:0]        data_out,
	output logic               ready,
	output synth_pkg::sample_t pcm_sample, // Stream for a later mixer
	output logic               pcm_valid,
	output logic               pwmout
);

	import synth_pkg::*;

	voice_cfg_t cfg [NUM_VOICES];
	sample_t    voice_out [NUM_VOICES];
	logic       sample_tick;

	synth_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.addr       (addr),
		.data_in    (data_in),
		.wen        (wen),
		.ren        (ren),
		.data_out   (data_out),
		.ready      (ready),
		.cfg        (cfg),
		.sample_tick(sample_tick)
	);

	// Waveform per slot from the table
	for (genvar v = 0; v < NUM_VOICES; v++) begin : g_voice
		voice #(.WAVE(VOICE_WAVE[v])) u_voice (
			.clk        (clk),
			.rst        (rst),
			.sample_tick(sample_tick),
			.cfg        (cfg[v]),
			.out        (voice_out[v])
		);
	end

	voice_mixer u_mixer (
		.clk        (clk),
		.rst        (rst),
		.sample_tick(sample_tick),
		.voice_out  (voice_out),
		.pcm_sample (pcm_sample),
		.pcm_valid  (pcm_valid)
	);

	sd_dac u_dac (
		.clk   (clk),
		.rst   (rst),
		.pcm   (pcm_sample),
		.pwmout(pwmout)
	);

endmodule

// File: synth_pkg.sv
// ----------------------------------------------------------------------
// Shared synthesizer sizes, waveform kinds, voice settings
// and the per-voice waveform table
// ----------------------------------------------------------------------
package synth_pkg;

	localparam int BITDEPTH   = 14; // Waveform, voice and mix width
	localparam int NUM_VOICES = 8;
	localparam int VSEL_BITS  = $clog2(NUM_VOICES); // Voice select width and mix shift
	localparam int SAMPLE_DIV = 8;  // 256 clk cycles per sample tick
	localparam int INC_BITS   = 16; // Phase increment and accumulator
	localparam int AR_BITS    = 8;  // Attack/release rate
	localparam int ENV_BITS   = 16; // Envelope level
	localparam int AMP_BITS   = 8;  // Level bits used for scaling
	localparam int ENV_STEP_SHIFT = 4; // Rate times 16 per tick

	// Register offsets inside a voice slot
	localparam logic [3:0] REG_PLAY = 4'h0;
	localparam logic [3:0] REG_AR   = 4'h4;

	typedef logic [BITDEPTH-1:0] sample_t;

	typedef enum logic [1:0] {
		SAW,
		PULSE,
		TRI
	} wave_e;

	// One voice's settings as written by the CPU
	typedef struct packed {
		logic                gate;
		logic [INC_BITS-1:0] inc;    // Phase step per tick
		logic [AR_BITS-1:0]  attack;
		logic [AR_BITS-1:0]  rel;    // Release rate
	} voice_cfg_t;

	// Two saws, two pulses, four triangles
	localparam wave_e VOICE_WAVE [NUM_VOICES] = '{
		SAW, SAW, PULSE, PULSE, TRI, TRI, TRI, TRI
	};

	localparam voice_cfg_t CFG_RESET = '{
		gate:   1'b0,
		inc:    16'd6000, // About 11 ticks per waveform period
		attack: 8'hF0,
		rel:    8'hF0
	};

endpackage

// File: tb_synth.sv
// ----------------------------------------------------------------------
// Synth testbench: replays bus traffic and expected samples from the
// golden file, checks readback, mixed samples and DAC density
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_synth;

	import synth_pkg::*;

	localparam time   CLK_PERIOD  = 40ns;
	localparam time   DRIVE_DELAY = 2ns;  // Input skew after the rising edge
	localparam int    RST_CYCLES  = 2;
	localparam int    BUS_TIMEOUT = 32;   // Cycles to wait for ready
	localparam int    PCM_TIMEOUT = 600;  // A bit over two sample periods
	localparam int    PWM_WINDOW  = 256;
	localparam string GOLDEN_FILE = "synth_golden.txt";

	logic        clk;
	logic        rst;
	logic [7:0]  addr;
	logic [31:0] data_in;
	logic        wen;
	logic        ren;
	logic [31:0] data_out;
	logic        ready;
	sample_t     pcm_sample;
	logic        pcm_valid;
	logic        pwmout;

	integer      seed;      // Idle gap generator state
	sample_t     held_exp;  // Last expected sample, used by the DAC window

	synth_interface DUT (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.data_in   (data_in),
		.wen       (wen),
		.ren       (ren),
		.data_out  (data_out),
		.ready     (ready),
		.pcm_sample(pcm_sample),
		.pcm_valid (pcm_valid),
		.pwmout    (pwmout)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual, input int unsigned tol);
		logic [31:0] diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if ($isunknown(actual) || diff > tol) begin
			abort_run($sformatf("ERROR time %0t: %s expected %0h actual %0h",
				$time, name, expected, actual));
		end
	endtask

	// Golden line must carry the right number of fields
	task automatic require_fields(input int got, input int want, input string op);
		if (got != want) begin
			abort_run($sformatf("Malformed %s line in the golden file", op));
		end
	endtask

	// One strobe/ready handshake, write or read
	task automatic bus_access(input logic write, input logic [7:0] a,
			input logic [31:0] d, output logic [31:0] rd);
		int gap;
		int waited;
		gap    = 1 + ($random(seed) & 3); // 1 to 4 idle cycles
		waited = 0;
		repeat (gap) @(posedge clk);
		#DRIVE_DELAY;
		addr    = a;
		data_in = write ? d : 32'h0;
		wen     = write;
		ren     = ~write;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
			if (waited > BUS_TIMEOUT) begin
				abort_run($sformatf("Timeout: no ready for the bus access at %h", a));
			end
		end while (!ready);
		rd = data_out;  // Valid while ready is high
		@(posedge clk); // Write commits on this edge
		#DRIVE_DELAY;
		wen     = 1'b0;
		ren     = 1'b0;
		addr    = 8'h0;
		data_in = 32'h0;
		#1;
		check_value("ready", 32'h0, 32'(ready), 0); // Drops with the strobe
	endtask

	task automatic wait_sample(output sample_t s);
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			waited++;
			if (waited > PCM_TIMEOUT) begin
				abort_run("Timeout: the mixer sent no pcm_valid pulse");
			end
		end while (!pcm_valid);
		s = pcm_sample;
	endtask

	// Ones on pwmout over a fixed window
	task automatic count_ones(output int ones);
		ones = 0;
		repeat (PWM_WINDOW) begin
			@(posedge clk);
			#DRIVE_DELAY;
			ones += int'(pwmout);
		end
	endtask

	initial begin
		string       op;
		string       rest;
		int          fd;
		int          code;
		int          ops;
		int          ones;
		logic [7:0]  a;
		logic [31:0] d;
		logic [31:0] rd;
		sample_t     got;

		seed     = 32'hb9e5;
		held_exp = '0;
		ops      = 0;
		clk      = 1'b0;
		rst      = 1'b1;
		addr     = 8'h0;
		data_in  = 32'h0;
		wen      = 1'b0;
		ren      = 1'b0;

		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		check_value("ready", 32'h0, 32'(ready), 0);
		check_value("pcm_valid", 32'h0, 32'(pcm_valid), 0);
		check_value("pwmout", 32'h0, 32'(pwmout), 0);
		check_value("data_out", 32'h0, data_out, 0);

		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0) begin
			abort_run("Cannot open synth_golden.txt for reading");
		end
		while ($fscanf(fd, "%s", op) == 1) begin
			case (op)
				"#": code = $fgets(rest, fd); // Comment, skip the line
				"W": begin
					code = $fscanf(fd, "%h %h", a, d);
					require_fields(code, 2, op);
					bus_access(1'b1, a, d, rd);
					ops++;
				end
				"R": begin
					code = $fscanf(fd, "%h %h", a, d);
					require_fields(code, 2, op);
					bus_access(1'b0, a, 32'h0, rd);
					check_value($sformatf("data_out at %h", a), d, rd, 0);
					ops++;
				end
				"S": begin
					code = $fscanf(fd, "%h", d);
					require_fields(code, 1, op);
					held_exp = sample_t'(d);
					wait_sample(got);
					check_value("pcm_sample", d, 32'(got), 0);
					ops++;
				end
				"P": begin
					count_ones(ones); // Held sample times window over full scale
					check_value("pwmout ones",
						(32'(held_exp) * PWM_WINDOW) >> BITDEPTH, ones, 1);
					ops++;
				end
				default: abort_run($sformatf("Unknown golden operation %s", op));
			endcase
		end
		$fclose(fd);

		if (ops == 0) begin
			abort_run("The golden file held no operations");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

// File: voice.sv
// ----------------------------------------------------------------------
// Synth voice: phase accumulator oscillator with a fixed waveform,
// linear attack/release envelope and amplitude scaling
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module voice #(
	parameter synth_pkg::wave_e WAVE = synth_pkg::SAW
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  sample_tick,
	input  synth_pkg::voice_cfg_t cfg,
	output synth_pkg::sample_t    out
);

	import synth_pkg::*;

	typedef enum logic [1:0] {
		ENV_IDLE,    // Silent, level at zero
		ENV_ATTACK,  // Rising toward full scale
		ENV_SUSTAIN, // Full scale, gate held
		ENV_RELEASE  // Falling toward zero
	} env_state_e;

	env_state_e            state, state_n;
	logic [INC_BITS-1:0]   phase, phase_n;
	logic [ENV_BITS-1:0]   level, level_n;
	logic                  gate_q;     // Gate as seen at the last tick
	logic                  rise;
	logic [INC_BITS-1:0]   base_phase;
	logic [ENV_BITS-1:0]   base_level;
	logic [ENV_BITS-1:0]   att_step, rel_step;
	logic [ENV_BITS:0]     up_sum;     // Extra bit catches overflow
	sample_t               wave;
	logic [BITDEPTH+AMP_BITS-1:0] scaled;

	assign rise = cfg.gate & ~gate_q;

	// A new note restarts phase and envelope
	assign base_phase = rise ? '0 : phase;
	assign base_level = rise ? '0 : level;
	assign phase_n    = base_phase + cfg.inc;

	assign att_step = ENV_BITS'(cfg.attack) << ENV_STEP_SHIFT;
	assign rel_step = ENV_BITS'(cfg.rel) << ENV_STEP_SHIFT;
	assign up_sum   = {1'b0, base_level} + {1'b0, att_step};

	// Envelope next level and state
	always_comb begin
		state_n = state;
		level_n = level;
		if (cfg.gate) begin
			if (state == ENV_SUSTAIN && !rise) begin
				level_n = level; // Already full scale
			end else begin
				level_n = up_sum[ENV_BITS] ? '1 : up_sum[ENV_BITS-1:0];
			end
			state_n = (level_n == '1) ? ENV_SUSTAIN : ENV_ATTACK;
		end else begin
			if (state == ENV_IDLE) begin
				level_n = '0;
			end else if (base_level < rel_step) begin
				level_n = '0; // Floor at zero
			end else begin
				level_n = base_level - rel_step;
			end
			state_n = (level_n == '0) ? ENV_IDLE : ENV_RELEASE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= ENV_IDLE;
			phase  <= '0;
			level  <= '0;
			gate_q <= 1'b0;
		end else if (sample_tick) begin
			state  <= state_n;
			phase  <= phase_n;
			level  <= level_n;
			gate_q <= cfg.gate;
		end
	end

	// Waveform from the current phase
	always_comb begin
		case (WAVE)
			SAW:     wave = phase[INC_BITS-1 -: BITDEPTH];
			PULSE:   wave = phase[INC_BITS-1] ? '1 : '0;
			TRI:     wave = phase[INC_BITS-1] ? ~phase[BITDEPTH:1] : phase[BITDEPTH:1];
			default: wave = '0;
		endcase
	end

	// Scale by the top envelope bits, back to sample width
	assign scaled = wave * level[ENV_BITS-1 -: AMP_BITS];
	assign out    = scaled[BITDEPTH+AMP_BITS-1:AMP_BITS];

endmodule

// File: voice_mixer.sv
// ----------------------------------------------------------------------
// Voice mixer that registers the average of all voices once per tick
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module voice_mixer (
	input  logic               clk,
	input  logic               rst,
	input  logic               sample_tick,
	input  synth_pkg::sample_t voice_out [synth_pkg::NUM_VOICES],
	output synth_pkg::sample_t pcm_sample,
	output logic               pcm_valid
);

	import synth_pkg::*;

	logic                          tick_q; // Voices settled one cycle after tick
	logic [BITDEPTH+VSEL_BITS-1:0] sum;

	always_comb begin
		sum = '0;
		for (int i = 0; i < NUM_VOICES; i++) begin
			sum = sum + (BITDEPTH+VSEL_BITS)'(voice_out[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tick_q     <= 1'b0;
			pcm_valid  <= 1'b0;
			pcm_sample <= '0; // Silent until the first mixed sample
		end else begin
			tick_q    <= sample_tick;
			pcm_valid <= tick_q;
			if (tick_q) begin
				pcm_sample <= sum[BITDEPTH+VSEL_BITS-1:VSEL_BITS]; // Divide by voice count
			end
		end
	end

endmodule
